/* all.f */
+incdir+tests
design/soc_pkg.sv
design/iob_split.sv
design/boot_ctrl.sv
design/boot_rom.sv
design/soc_sram.sv
design/soc_timer.sv
design/soc_top.sv
tests/tb_soc_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_soc_top -o sim_tb_soc_top

out=$(./obj_dir/sim_tb_soc_top)
echo "$out"

if grep -q "TESTBENCH PASSED" <<< "$out"; then
   exit 0
else
   exit 1
fi

/* tests/tb_soc_tasks.svh */
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

// Expected read data, from the ROM rule or the shadow SRAM
function automatic logic [31:0] ref_word(input logic from_rom, input logic [15:0] addr);
   if (from_rom) begin
      return {soc_pkg::ROM_TAG, 10'b0, addr[7:2]};
   end
   return shadow[addr[9:2]];
endfunction

function automatic logic [15:0] sram_addr(input logic [7:0] idx);
   return {6'b0, idx, 2'b00};
endfunction

task automatic shadow_write(input logic [15:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
   for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
   end
endtask

task automatic check_resp(input string name, input soc_pkg::iob_resp_t got,
                          input logic [31:0] exp);
   checks++;
   if (got.rdata !== exp) begin
      errors++;
      $display("Error: %s.rdata got %h expected %h", name, got.rdata, exp);
   end
endtask

task automatic check_level(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
   end
endtask

task automatic dbus_write(input logic [15:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb);
   @(posedge clk_i);
   dbus_req_i <= '{avalid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
   if (!addr[15]) shadow_write(addr, wdata, wstrb);
endtask

task automatic dbus_read(input logic [15:0] addr, input logic [31:0] exp);
   @(posedge clk_i);
   dbus_req_i <= '{avalid: 1'b1, addr: addr, wdata: 32'h0, wstrb: 4'h0};
   dexp_q.push_back(exp);
endtask

task automatic ibus_read(input logic [15:0] addr, input logic [31:0] exp);
   @(posedge clk_i);
   ibus_req_i <= '{avalid: 1'b1, addr: addr, wdata: 32'h0, wstrb: 4'h0};
   iexp_q.push_back(exp);
endtask

task automatic bus_idle();
   @(posedge clk_i);
   ibus_req_i <= '0;
   dbus_req_i <= '0;
endtask

// Let the last responses come back
task automatic drain();
   repeat (3) bus_idle();
endtask

task automatic end_test(input string name);
   tests++;
   $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
   test_err_base = errors;
endtask

`endif

/* tests/tb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

   // Rough length of all tests plus slack
   localparam int RUN_CYCLES = 250;
   localparam int MARGIN     = 250;
   localparam int N_WORDS    = 12;

   logic               clk_i;
   logic               rst_n_i;
   soc_pkg::iob_req_t  ibus_req_i;
   soc_pkg::iob_req_t  dbus_req_i;
   soc_pkg::iob_resp_t ibus_resp_o;
   soc_pkg::iob_resp_t dbus_resp_o;
   logic               boot_o;
   logic               cpu_rst_o;

   logic [31:0] lfsr = 32'h99b571c4;
   logic [31:0] shadow [256];
   logic [7:0]  word_idx [N_WORDS];
   logic [31:0] iexp_q [$];
   logic [31:0] dexp_q [$];
   logic        ipend = 1'b0;
   logic        dpend = 1'b0;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_err_base = 0;
   int          cycle_cnt = 0;

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return v;
   endfunction

`include "tb_soc_tasks.svh"

   soc_top u_soc_top (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .ibus_req_i (ibus_req_i),
      .dbus_req_i (dbus_req_i),
      .ibus_resp_o(ibus_resp_o),
      .dbus_resp_o(dbus_resp_o),
      .boot_o     (boot_o),
      .cpu_rst_o  (cpu_rst_o)
   );

   initial clk_i = 1'b0;
   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= RUN_CYCLES + MARGIN) begin
         $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Rvalid must follow each accepted read by one cycle
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         ipend = 1'b0;
         dpend = 1'b0;
      end else begin
         check_level("ibus_resp_o.rvalid", ibus_resp_o.rvalid, ipend);
         if (ipend && ibus_resp_o.rvalid === 1'b1) begin
            check_resp("ibus_resp_o", ibus_resp_o, iexp_q.pop_front());
         end
         check_level("dbus_resp_o.rvalid", dbus_resp_o.rvalid, dpend);
         if (dpend && dbus_resp_o.rvalid === 1'b1) begin
            check_resp("dbus_resp_o", dbus_resp_o, dexp_q.pop_front());
         end
         ipend = ibus_req_i.avalid && ibus_resp_o.ready && (ibus_req_i.wstrb == '0);
         dpend = dbus_req_i.avalid && dbus_resp_o.ready && (dbus_req_i.wstrb == '0);
      end
   end

   initial begin
      logic [15:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      logic [31:0] cnt_exp;
      int          n;
      rst_n_i    = 1'b0;
      ibus_req_i = '0;
      dbus_req_i = '0;
      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);

      // Boot ROM fetch
      check_level("boot_o", boot_o, 1'b1);
      check_level("cpu_rst_o", cpu_rst_o, 1'b0);
      for (int i = 0; i < 16; i++) begin
         d = rand_bits(6);
         a = {8'h00, d[5:0], 2'b00};
         ibus_read(a, ref_word(1'b1, a));
      end
      drain();
      end_test("rom_fetch");

      // Full word writes first so no byte of the SRAM stays unknown
      for (int i = 0; i < N_WORDS; i++) begin
         d           = rand_bits(8);
         word_idx[i] = d[7:0];
         dbus_write(sram_addr(word_idx[i]), rand_bits(32), 4'hf);
      end
      for (int i = 0; i < N_WORDS; i++) begin
         a = sram_addr(word_idx[i]);
         d = rand_bits(32);
         s = 4'(rand_bits(4));
         if (s == 4'h0) s = 4'h1;
         dbus_write(a, d, s);
         dbus_read(a, ref_word(1'b0, a));
      end
      for (int i = 0; i < N_WORDS; i++) begin
         a = sram_addr(word_idx[i]);
         dbus_read(a, ref_word(1'b0, a));
      end
      drain();
      end_test("sram_data");

      // End of boot and CPU reset stretch
      dbus_read(16'h8000, 32'h1);
      drain();
      dbus_write(16'h8000, 32'h0, 4'hf);
      bus_idle();
      @(negedge clk_i);
      check_level("boot_o", boot_o, 1'b1);
      check_level("cpu_rst_o", cpu_rst_o, 1'b0);
      repeat (soc_pkg::CPU_RST_CYCLES) begin
         @(posedge clk_i);
         @(negedge clk_i);
         check_level("cpu_rst_o", cpu_rst_o, 1'b1);
         check_level("boot_o", boot_o, 1'b0);
      end
      @(posedge clk_i);
      @(negedge clk_i);
      check_level("cpu_rst_o", cpu_rst_o, 1'b0);
      check_level("boot_o", boot_o, 1'b0);
      $display("boot state %s", u_soc_top.u_boot_ctrl.state_q.name());
      if (u_soc_top.u_boot_ctrl.state_q != soc_pkg::RUN) begin
         errors++;
         $display("Boot controller did not reach RUN after the reset stretch");
      end
      dbus_read(16'h8000, 32'h0);
      drain();
      end_test("boot_end");

      // Fetch now comes from SRAM
      for (int i = 0; i < N_WORDS; i++) begin
         a = sram_addr(word_idx[i]);
         ibus_read(a, ref_word(1'b0, a));
      end
      drain();
      end_test("sram_fetch");

      // Timer counts edges from enable to disable acceptance
      d = rand_bits(6);
      n = int'(d) + 4;
      dbus_write(16'hc000, 32'h1, 4'hf);
      repeat (n) bus_idle();
      dbus_write(16'hc000, 32'h0, 4'hf);
      cnt_exp = 32'(n + 1);
      bus_idle();
      dbus_read(16'hc004, cnt_exp);
      dbus_read(16'hc004, cnt_exp);
      drain();
      end_test("timer_count");

      // Back to back reads alternating between followers
      for (int i = 0; i < 6; i++) begin
         a = sram_addr(word_idx[i]);
         dbus_read(a, ref_word(1'b0, a));
         dbus_read(16'h8000, 32'h0);
         dbus_read(16'hc004, cnt_exp);
      end
      drain();
      end_test("mixed_reads");

      dbus_write(16'hc000, 32'h2, 4'hf);
      dbus_read(16'hc004, 32'h0);
      dbus_read(16'hc000, 32'h0);
      drain();
      end_test("timer_clear");

      if (iexp_q.size() != 0 || dexp_q.size() != 0) begin
         errors++;
         $display("Reads still waiting for a response at the end of the run");
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory and boot subsystem, CPU buses come from outside
module soc_top (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  soc_pkg::iob_req_t  ibus_req_i,
   input  soc_pkg::iob_req_t  dbus_req_i,
   output soc_pkg::iob_resp_t ibus_resp_o,
   output soc_pkg::iob_resp_t dbus_resp_o,
   output logic               boot_o,
   output logic               cpu_rst_o
);

   // ibus followers, 0 is SRAM port A and 1 is the boot ROM
   soc_pkg::iob_req_t  ibus_f_req  [2];
   soc_pkg::iob_resp_t ibus_f_resp [2];

   // dbus followers, 0 is SRAM port B and 1 is the peripheral bus
   soc_pkg::iob_req_t  dbus_f_req  [2];
   soc_pkg::iob_resp_t dbus_f_resp [2];

   // Peripheral followers, 0 is boot_ctrl and 1 is the timer
   soc_pkg::iob_req_t  pbus_f_req  [2];
   soc_pkg::iob_resp_t pbus_f_resp [2];

   // Fetch goes to ROM while booting
   iob_split #(
      .N(2)
   ) ibus_split (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (ibus_req_i),
      .m_resp_o(ibus_resp_o),
      .f_req_o (ibus_f_req),
      .f_resp_i(ibus_f_resp),
      .f_sel_i (boot_o)
   );

   // Top address bit picks memory or peripherals
   iob_split #(
      .N(2)
   ) dbus_split (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (dbus_req_i),
      .m_resp_o(dbus_resp_o),
      .f_req_o (dbus_f_req),
      .f_resp_i(dbus_f_resp),
      .f_sel_i (dbus_req_i.addr[soc_pkg::ADDR_W-1])
   );

   // Next bit down picks the peripheral
   iob_split #(
      .N(2)
   ) pbus_split (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .m_req_i (dbus_f_req[1]),
      .m_resp_o(dbus_f_resp[1]),
      .f_req_o (pbus_f_req),
      .f_resp_i(pbus_f_resp),
      .f_sel_i (dbus_f_req[1].addr[soc_pkg::ADDR_W-2])
   );

   boot_rom u_boot_rom (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (ibus_f_req[1]),
      .resp_o (ibus_f_resp[1])
   );

   soc_sram u_soc_sram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .ireq_i (ibus_f_req[0]),
      .dreq_i (dbus_f_req[0]),
      .iresp_o(ibus_f_resp[0]),
      .dresp_o(dbus_f_resp[0])
   );

   boot_ctrl u_boot_ctrl (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (pbus_f_req[0]),
      .resp_o   (pbus_f_resp[0]),
      .boot_o   (boot_o),
      .cpu_rst_o(cpu_rst_o)
   );

   soc_timer u_soc_timer (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (pbus_f_req[1]),
      .resp_o (pbus_f_resp[1])
   );

endmodule

`default_nettype wire

/* design/soc_timer.sv */
`timescale 1ns/1ps
`default_nettype none

// Cycle counter, CTRL at offset 0 and COUNT at offset 4
module soc_timer (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  soc_pkg::iob_req_t  req_i,
   output soc_pkg::iob_resp_t resp_o
);

   logic                       en_q;
   logic [soc_pkg::DATA_W-1:0] count_q;
   logic [soc_pkg::DATA_W-1:0] rdata_q;
   logic                       rvalid_q;
   logic                       wr_ctrl;
   logic                       rd_en;

   // COUNT is read only, writes there are dropped
   assign wr_ctrl = req_i.avalid && (req_i.wstrb != '0) && !req_i.addr[2];
   assign rd_en   = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         count_q  <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
         if (wr_ctrl) en_q <= req_i.wdata[0];
         // clear wins over counting
         if (wr_ctrl && req_i.wdata[1]) begin
            count_q <= '0;
         end else if (en_q) begin
            count_q <= count_q + 1;
         end
      end
   end

   // Clear is a pulse, so it always reads back as 0
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= req_i.addr[2] ? count_q : {{(soc_pkg::DATA_W-1){1'b0}}, en_q};
      end
   end

   assign resp_o = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};

endmodule

`default_nettype wire

/* design/soc_sram.sv */
`timescale 1ns/1ps
`default_nettype none

// Shared SRAM, port A fetches, port B is the data side
module soc_sram (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  soc_pkg::iob_req_t  ireq_i,
   input  soc_pkg::iob_req_t  dreq_i,
   output soc_pkg::iob_resp_t iresp_o,
   output soc_pkg::iob_resp_t dresp_o
);

   logic [soc_pkg::DATA_W-1:0]      mem [2**soc_pkg::SRAM_ADDR_W];
   logic [soc_pkg::SRAM_ADDR_W-1:0] iaddr;
   logic [soc_pkg::SRAM_ADDR_W-1:0] daddr;
   logic [soc_pkg::DATA_W-1:0]      irdata_q;
   logic [soc_pkg::DATA_W-1:0]      drdata_q;
   logic                            irvalid_q;
   logic                            drvalid_q;
   logic                            i_rd;
   logic                            d_rd;

   assign iaddr = ireq_i.addr[soc_pkg::SRAM_ADDR_W+1:2];
   assign daddr = dreq_i.addr[soc_pkg::SRAM_ADDR_W+1:2];
   assign i_rd  = ireq_i.avalid && (ireq_i.wstrb == '0);
   assign d_rd  = dreq_i.avalid && (dreq_i.wstrb == '0);

   // Port A, read only
   always_ff @(posedge clk_i) begin
      if (i_rd) irdata_q <= mem[iaddr];
   end

   // Port B, byte lanes written under their strobes
   always_ff @(posedge clk_i) begin
      if (dreq_i.avalid) begin
         for (int b = 0; b < soc_pkg::DATA_W/8; b++) begin
            if (dreq_i.wstrb[b]) mem[daddr][8*b +: 8] <= dreq_i.wdata[8*b +: 8];
         end
      end
      if (d_rd) drdata_q <= mem[daddr];
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         irvalid_q <= 1'b0;
         drvalid_q <= 1'b0;
      end else begin
         irvalid_q <= i_rd;
         drvalid_q <= d_rd;
      end
   end

   assign iresp_o = '{rdata: irdata_q, rvalid: irvalid_q, ready: 1'b1};
   assign dresp_o = '{rdata: drdata_q, rvalid: drvalid_q, ready: 1'b1};

   // Fetch side never writes
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ireq_i.avalid |-> (ireq_i.wstrb == '0))
      else $error("soc_sram: write on instruction port");

endmodule

`default_nettype wire

/* design/boot_rom.sv */
`timescale 1ns/1ps
`default_nettype none

// Boot image, read one cycle after acceptance
module boot_rom (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  soc_pkg::iob_req_t  req_i,
   output soc_pkg::iob_resp_t resp_o
);

   logic [soc_pkg::ROM_ADDR_W-1:0] word_idx;
   logic [soc_pkg::DATA_W-1:0]     rdata_q;
   logic                           rvalid_q;
   logic                           rd_en;

   // Image word is the tag over its own index
   function automatic logic [soc_pkg::DATA_W-1:0] rom_word(
      input logic [soc_pkg::ROM_ADDR_W-1:0] idx
   );
      return {soc_pkg::ROM_TAG, 16'(idx)};
   endfunction

   assign word_idx = req_i.addr[soc_pkg::ROM_ADDR_W+1:2];
   // Writes are taken and dropped
   assign rd_en    = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) rdata_q <= rom_word(word_idx);
   end

   assign resp_o = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};

endmodule

`default_nettype wire

/* design/boot_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Boot controller with the CTR register at offset 0
module boot_ctrl (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  soc_pkg::iob_req_t  req_i,
   output soc_pkg::iob_resp_t resp_o,
   output logic               boot_o,
   output logic               cpu_rst_o
);

   soc_pkg::boot_state_t          state_q;
   logic [soc_pkg::RST_CNT_W-1:0] rst_cnt_q;
   logic                          boot_q;
   logic                          cpu_rst_q;
   logic                          restart_q;
   logic                          wr_en;
   logic                          rd_en;
   logic                          rvalid_q;
   logic [soc_pkg::DATA_W-1:0]    rdata_q;

   assign wr_en = req_i.avalid && (req_i.wstrb != '0);
   assign rd_en = req_i.avalid && (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= soc_pkg::BOOT;
         boot_q    <= 1'b1;
         cpu_rst_q <= 1'b0;
         rst_cnt_q <= '0;
         restart_q <= 1'b0;
      end else begin
         // Clearing the boot flag is acted on one cycle after acceptance
         restart_q <= wr_en && !req_i.wdata[0] && (state_q == soc_pkg::BOOT);
         case (state_q)
            soc_pkg::BOOT: begin
               if (restart_q) begin
                  state_q   <= soc_pkg::RESTART;
                  boot_q    <= 1'b0;
                  cpu_rst_q <= 1'b1;
                  rst_cnt_q <= soc_pkg::RST_CNT_LOAD;
               end
            end
            soc_pkg::RESTART: begin
               if (rst_cnt_q == '0) begin
                  state_q   <= soc_pkg::RUN;
                  cpu_rst_q <= 1'b0;
               end else begin
                  rst_cnt_q <= rst_cnt_q - 1;
               end
            end
            // RUN holds until the next reset
            default: ;
         endcase
      end
   end

   // CTR readback
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) rdata_q <= {{(soc_pkg::DATA_W-1){1'b0}}, boot_q};
   end

   assign resp_o    = '{rdata: rdata_q, rvalid: rvalid_q, ready: 1'b1};
   assign boot_o    = boot_q;
   assign cpu_rst_o = cpu_rst_q;

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cpu_rst_q |-> (state_q == soc_pkg::RESTART))
      else $error("boot_ctrl: CPU reset outside RESTART");

   // The flag may only come back through a system reset
   assert property (@(posedge clk_i) $rose(boot_q) |-> $past(!rst_n_i))
      else $error("boot_ctrl: boot flag rose without reset");

endmodule

`default_nettype wire

/* design/iob_split.sv */
`timescale 1ns/1ps
`default_nettype none

// One master to N followers, chosen by f_sel_i
module iob_split #(
   parameter  int N     = 2,
   localparam int SEL_W = (N > 1) ? $clog2(N) : 1
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   // Master side
   input  soc_pkg::iob_req_t  m_req_i,
   output soc_pkg::iob_resp_t m_resp_o,
   // Follower side
   output soc_pkg::iob_req_t  f_req_o  [N],
   input  soc_pkg::iob_resp_t f_resp_i [N],
   input  logic [SEL_W-1:0]   f_sel_i
);

   logic [SEL_W-1:0] rsp_sel_q;
   logic             rd_acc;

   // A read is taken when valid meets ready with no strobes
   assign rd_acc = m_req_i.avalid && m_resp_o.ready && (m_req_i.wstrb == '0);

   // Request fan-out, only the selected follower sees avalid
   always_comb begin
      for (int i = 0; i < N; i++) begin
         f_req_o[i]        = m_req_i;
         f_req_o[i].avalid = m_req_i.avalid && (f_sel_i == SEL_W'(i));
      end
   end

   // Ready follows the current select, read data the registered one
   always_comb begin
      m_resp_o.ready  = f_resp_i[f_sel_i].ready;
      m_resp_o.rdata  = f_resp_i[rsp_sel_q].rdata;
      m_resp_o.rvalid = f_resp_i[rsp_sel_q].rvalid;
   end

   // Remember who owes the next response
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rsp_sel_q <= '0;
      end else if (rd_acc) begin
         rsp_sel_q <= f_sel_i;
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_req_i.avalid |-> (int'(f_sel_i) < N))
      else $error("iob_split: follower select %0d out of range", f_sel_i);

   // Any response on the master side answers a read taken one cycle before
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_resp_o.rvalid |-> $past(rd_acc))
      else $error("iob_split: rvalid without a read in the previous cycle");

endmodule

`default_nettype wire

/* design/soc_pkg.sv */
`default_nettype none

package soc_pkg;

   // Bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // Memory sizes in words
   localparam int SRAM_ADDR_W = 8;
   localparam int ROM_ADDR_W  = 6;

   // CPU reset stretch after boot
   localparam int CPU_RST_CYCLES = 4;
   localparam int RST_CNT_W      = $clog2(CPU_RST_CYCLES + 1);
   localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(CPU_RST_CYCLES - 1);

   // Upper half of every boot image word
   localparam logic [15:0] ROM_TAG = 16'hb007;

   // Native bus request, wstrb of zero is a read
   typedef struct packed {
      logic                avalid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   // Native bus response
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_resp_t;

   typedef enum logic [1:0] {
      BOOT,
      RESTART,
      RUN
   } boot_state_t;

endpackage

`default_nettype wire
